// File: hw/periph_bus_decoder.sv
/*
 * Host port and address decoder of the peripheral bus
 *  - one transaction in flight, accept / select / respond
 *  - slave select from the address slave-index field
 *  - error response for unmapped addresses
 */
`include "periph_defs.svh"

module periph_bus_decoder
   import periph_pkg::*;
(
   input  logic                                    clk_i,
   input  logic                                    rst_i,
   input  logic                                    req_valid_i,
   output logic                                    req_ready_o,
   input  periph_req_t                             req_i,
   output logic                                    rsp_valid_o,
   input  logic                                    rsp_ready_i,
   output periph_rsp_t                             rsp_o,
   output periph_req_t                             slv_req_o,
   output logic [`PERIPH_NUM_SLAVES-1:0]           slv_sel_o,
   input  periph_rsp_t [`PERIPH_NUM_SLAVES-1:0]    slv_rsp_i
);

   typedef enum logic [1:0] {ST_IDLE, ST_SEL, ST_RSP} state_e;

   state_e                         state_q;
   periph_req_t                    req_q;
   logic [`PERIPH_NUM_SLAVES-1:0]  sel_d;
   logic [`PERIPH_NUM_SLAVES-1:0]  sel_q;
   logic                           mapped;

   assign mapped = (req_i.addr.fields.upper == '0);

   always_comb begin
      for (int s = 0; s < `PERIPH_NUM_SLAVES; s++) begin
         sel_d[s] = mapped && (req_i.addr.fields.slv_idx == 4'(s));
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= ST_IDLE;
         sel_q   <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (req_valid_i) begin
                  state_q <= ST_SEL;
                  sel_q   <= sel_d;
               end
            end
            ST_SEL:  state_q <= ST_RSP;
            ST_RSP:  if (rsp_ready_i) state_q <= ST_IDLE;
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_valid_i && req_ready_o) req_q <= req_i;
   end

   assign req_ready_o = (state_q == ST_IDLE);
   assign rsp_valid_o = (state_q == ST_RSP);
   assign slv_req_o   = req_q;
   assign slv_sel_o   = (state_q == ST_SEL) ? sel_q : '0;

   // Slave holds its response register until its next select
   always_comb begin
      rsp_o = '{rdata: '0, err: 1'b1};
      for (int s = 0; s < `PERIPH_NUM_SLAVES; s++) begin
         if (sel_q[s]) rsp_o = slv_rsp_i[s];
      end
   end

   // One select bit, matching the request seen by the peripherals
   a_sel_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
      slv_sel_o != '0 |-> slv_req_o.addr.fields.upper == '0
         && slv_sel_o == `PERIPH_NUM_SLAVES'(1 << slv_req_o.addr.fields.slv_idx));

   a_rsp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

endmodule

// File: hw/periph_defs.svh
/*
 * Peripheral subsystem constants
 *  - bus widths and slave count
 *  - slave indices carried in address bits 15:12
 *  - peripheral sizes and register word offsets
 */
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

`define PERIPH_DATA_W      32
`define PERIPH_ADDR_W      32
`define PERIPH_REG_OFF_W   6
`define PERIPH_NUM_SLAVES  3

`define PERIPH_SLV_GPIO    0
`define PERIPH_SLV_PWM     1
`define PERIPH_SLV_SOCCTRL 2

`define PERIPH_NUM_GPIO    16
`define PERIPH_PWM_CH      4
`define PERIPH_NUM_LLC_EV  4

`define PERIPH_GPIO_DIR    6'd0
`define PERIPH_GPIO_OUT    6'd1
`define PERIPH_GPIO_IN     6'd2
`define PERIPH_PWM_PERIOD  6'd0
`define PERIPH_PWM_DUTY0   6'd1
`define PERIPH_PWM_CTRL    6'd5
`define PERIPH_SOC_CLUSTER 6'd0
`define PERIPH_SOC_LLC0    6'd1

`endif

// File: hw/periph_gpio.sv
/*
 * GPIO peripheral
 *  - DIR and OUT registers driving the pins
 *  - two-stage input synchronizer read through IN
 */
`include "periph_defs.svh"

module periph_gpio
   import periph_pkg::*;
#(
   parameter int unsigned NUM_GPIO = `PERIPH_NUM_GPIO
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                sel_i,
   input  periph_req_t         req_i,
   output periph_rsp_t         rsp_o,
   input  logic [NUM_GPIO-1:0] gpio_i,
   output logic [NUM_GPIO-1:0] gpio_o,
   output logic [NUM_GPIO-1:0] gpio_oe_o
);

   logic [NUM_GPIO-1:0]          dir_q;
   logic [NUM_GPIO-1:0]          out_q;
   logic [NUM_GPIO-1:0]          sync1_q;
   logic [NUM_GPIO-1:0]          sync2_q;
   logic [`PERIPH_REG_OFF_W-1:0] reg_off;
   periph_rsp_t                  rsp_d;
   periph_rsp_t                  rsp_q;

   assign reg_off = req_i.addr.fields.reg_off;

   always_comb begin
      rsp_d = '0;
      case (reg_off)
         `PERIPH_GPIO_DIR: rsp_d.rdata[NUM_GPIO-1:0] = dir_q;
         `PERIPH_GPIO_OUT: rsp_d.rdata[NUM_GPIO-1:0] = out_q;
         `PERIPH_GPIO_IN: begin
            rsp_d.rdata[NUM_GPIO-1:0] = sync2_q;
            rsp_d.err = req_i.write;
         end
         default: rsp_d.err = 1'b1;
      endcase
      if (req_i.write) rsp_d.rdata = '0;
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         dir_q <= '0;
         out_q <= '0;
      end else if (sel_i && req_i.write) begin
         if (reg_off == `PERIPH_GPIO_DIR) dir_q <= req_i.wdata[NUM_GPIO-1:0];
         if (reg_off == `PERIPH_GPIO_OUT) out_q <= req_i.wdata[NUM_GPIO-1:0];
      end
   end

   always_ff @(posedge clk_i) begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      if (sel_i) rsp_q <= rsp_d;
   end

   assign rsp_o     = rsp_q;
   assign gpio_o    = out_q;
   assign gpio_oe_o = dir_q;

endmodule

// File: hw/periph_pkg.sv
/*
 * Peripheral bus types
 *  - periph_addr_u: address as a raw word or as decoded fields
 *  - periph_req_t, periph_rsp_t: request and response of the bus
 *  - cluster_ctrl_t: cluster control bits
 */
`include "periph_defs.svh"

package periph_pkg;

   typedef struct packed {
      logic [`PERIPH_ADDR_W-17:0]    upper;
      logic [3:0]                    slv_idx;
      logic [3:0]                    unused;
      logic [`PERIPH_REG_OFF_W-1:0]  reg_off;
      logic [1:0]                    byte_off;
   } periph_addr_fields_t;

   typedef union packed {
      logic [`PERIPH_ADDR_W-1:0] raw;
      periph_addr_fields_t       fields;
   } periph_addr_u;

   typedef struct packed {
      logic                      write;
      periph_addr_u              addr;
      logic [`PERIPH_DATA_W-1:0] wdata;
   } periph_req_t;

   typedef struct packed {
      logic [`PERIPH_DATA_W-1:0] rdata;
      logic                      err;
   } periph_rsp_t;

   // Bit 0 is fetch enable
   typedef struct packed {
      logic rst;
      logic en_sa_boot;
      logic fetch_en;
   } cluster_ctrl_t;

endpackage

// File: hw/periph_pwm_timer.sv
/*
 * PWM timer
 *  - PERIOD, per-channel DUTY and CTRL registers
 *  - shared counter wrapping at PERIOD
 *  - one duty comparator per channel
 */
`include "periph_defs.svh"

module periph_pwm_timer
   import periph_pkg::*;
#(
   parameter int unsigned NUM_CH = `PERIPH_PWM_CH
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              sel_i,
   input  periph_req_t       req_i,
   output periph_rsp_t       rsp_o,
   output logic [NUM_CH-1:0] pwm_o
);

   localparam int CH_W = $clog2(NUM_CH);

   logic [`PERIPH_DATA_W-1:0]              period_q;
   logic [NUM_CH-1:0][`PERIPH_DATA_W-1:0]  duty_q;
   logic                                   en_q;
   logic [`PERIPH_DATA_W-1:0]              cnt_q;
   logic [`PERIPH_REG_OFF_W-1:0]           reg_off;
   logic [`PERIPH_REG_OFF_W-1:0]           ch_off;
   logic                                   duty_hit;
   logic [CH_W-1:0]                        duty_idx;
   periph_rsp_t                            rsp_d;
   periph_rsp_t                            rsp_q;

   assign reg_off  = req_i.addr.fields.reg_off;
   assign ch_off   = reg_off - `PERIPH_PWM_DUTY0;
   assign duty_hit = (ch_off < `PERIPH_REG_OFF_W'(NUM_CH));
   assign duty_idx = ch_off[CH_W-1:0];

   always_comb begin
      rsp_d = '0;
      case (reg_off)
         `PERIPH_PWM_PERIOD: rsp_d.rdata = period_q;
         `PERIPH_PWM_CTRL:   rsp_d.rdata = {31'b0, en_q};
         default: begin
            if (duty_hit) rsp_d.rdata = duty_q[duty_idx];
            else rsp_d.err = 1'b1;
         end
      endcase
      if (req_i.write) rsp_d.rdata = '0;
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         period_q <= '0;
         duty_q   <= '0;
         en_q     <= 1'b0;
      end else if (sel_i && req_i.write) begin
         if (reg_off == `PERIPH_PWM_PERIOD) period_q <= req_i.wdata;
         else if (reg_off == `PERIPH_PWM_CTRL) en_q <= req_i.wdata[0];
         else if (duty_hit) duty_q[duty_idx] <= req_i.wdata;
      end
   end

   // Counter restarts from 0 each time the timer is enabled
   always_ff @(posedge clk_i) begin
      if (rst_i || !en_q || cnt_q >= period_q) cnt_q <= '0;
      else cnt_q <= cnt_q + 32'd1;
   end

   always_ff @(posedge clk_i) begin
      if (sel_i) rsp_q <= rsp_d;
   end

   always_comb begin
      for (int n = 0; n < NUM_CH; n++) begin
         pwm_o[n] = en_q && (cnt_q < duty_q[n]);
      end
   end

   assign rsp_o = rsp_q;

   a_pwm_off: assert property (@(posedge clk_i) disable iff (rst_i)
      sel_i && req_i.write && reg_off == `PERIPH_PWM_CTRL && !req_i.wdata[0]
      |=> pwm_o == '0);

endmodule

// File: hw/periph_soc_control.sv
/*
 * SoC control peripheral
 *  - CLUSTER register with fetch enable, standalone boot and reset
 *  - saturating counters for the LLC events, cleared by a write
 */
`include "periph_defs.svh"

module periph_soc_control
   import periph_pkg::*;
(
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          sel_i,
   input  periph_req_t                   req_i,
   output periph_rsp_t                   rsp_o,
   // Read hit, read miss, write hit, write miss
   input  logic [`PERIPH_NUM_LLC_EV-1:0] llc_event_i,
   output cluster_ctrl_t                 cluster_ctrl_o
);

   localparam int EV_W = $clog2(`PERIPH_NUM_LLC_EV);

   cluster_ctrl_t                                     cluster_q;
   logic [`PERIPH_NUM_LLC_EV-1:0][`PERIPH_DATA_W-1:0] cnt_q;
   logic [`PERIPH_NUM_LLC_EV-1:0]                     clr;
   logic [`PERIPH_REG_OFF_W-1:0]                      reg_off;
   logic [`PERIPH_REG_OFF_W-1:0]                      ev_off;
   logic                                              llc_hit;
   logic [EV_W-1:0]                                   llc_idx;
   periph_rsp_t                                       rsp_d;
   periph_rsp_t                                       rsp_q;

   assign reg_off = req_i.addr.fields.reg_off;
   assign ev_off  = reg_off - `PERIPH_SOC_LLC0;
   assign llc_hit = (ev_off < `PERIPH_REG_OFF_W'(`PERIPH_NUM_LLC_EV));
   assign llc_idx = ev_off[EV_W-1:0];

   always_comb begin
      rsp_d = '0;
      if (reg_off == `PERIPH_SOC_CLUSTER) rsp_d.rdata = {29'b0, cluster_q};
      else if (llc_hit) rsp_d.rdata = cnt_q[llc_idx];
      else rsp_d.err = 1'b1;
      if (req_i.write) rsp_d.rdata = '0;
   end

   always_comb begin
      clr = '0;
      if (sel_i && req_i.write && llc_hit) clr[llc_idx] = 1'b1;
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cluster_q <= '{rst: 1'b1, en_sa_boot: 1'b0, fetch_en: 1'b0};
      end else if (sel_i && req_i.write && reg_off == `PERIPH_SOC_CLUSTER) begin
         cluster_q <= cluster_ctrl_t'(req_i.wdata[2:0]);
      end
   end

   // Clear from the bus wins over an event in the same cycle
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cnt_q <= '0;
      end else begin
         for (int k = 0; k < `PERIPH_NUM_LLC_EV; k++) begin
            if (clr[k]) cnt_q[k] <= '0;
            else if (llc_event_i[k] && cnt_q[k] != '1) cnt_q[k] <= cnt_q[k] + 32'd1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (sel_i) rsp_q <= rsp_d;
   end

   assign rsp_o          = rsp_q;
   assign cluster_ctrl_o = cluster_q;

endmodule

// File: hw/periph_subsystem.sv
/*
 * Peripheral subsystem top level
 *  - bus decoder on the host port
 *  - GPIO, PWM timer and SoC control on the peripheral bus
 */
`include "periph_defs.svh"

module periph_subsystem
   import periph_pkg::*;
(
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          req_valid_i,
   output logic                          req_ready_o,
   input  periph_req_t                   req_i,
   output logic                          rsp_valid_o,
   input  logic                          rsp_ready_i,
   output periph_rsp_t                   rsp_o,
   input  logic [`PERIPH_NUM_GPIO-1:0]   gpio_i,
   output logic [`PERIPH_NUM_GPIO-1:0]   gpio_o,
   output logic [`PERIPH_NUM_GPIO-1:0]   gpio_oe_o,
   output logic [`PERIPH_PWM_CH-1:0]     pwm_o,
   input  logic [`PERIPH_NUM_LLC_EV-1:0] llc_event_i,
   output cluster_ctrl_t                 cluster_ctrl_o
);

   periph_req_t                                slv_req;
   logic [`PERIPH_NUM_SLAVES-1:0]              slv_sel;
   periph_rsp_t [`PERIPH_NUM_SLAVES-1:0]       slv_rsp;

   periph_bus_decoder i_decoder (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_valid_i (req_valid_i),
      .req_ready_o (req_ready_o),
      .req_i       (req_i),
      .rsp_valid_o (rsp_valid_o),
      .rsp_ready_i (rsp_ready_i),
      .rsp_o       (rsp_o),
      .slv_req_o   (slv_req),
      .slv_sel_o   (slv_sel),
      .slv_rsp_i   (slv_rsp)
   );

   periph_gpio #(.NUM_GPIO(`PERIPH_NUM_GPIO)) i_gpio (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .sel_i     (slv_sel[`PERIPH_SLV_GPIO]),
      .req_i     (slv_req),
      .rsp_o     (slv_rsp[`PERIPH_SLV_GPIO]),
      .gpio_i    (gpio_i),
      .gpio_o    (gpio_o),
      .gpio_oe_o (gpio_oe_o)
   );

   periph_pwm_timer #(.NUM_CH(`PERIPH_PWM_CH)) i_pwm_timer (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .sel_i (slv_sel[`PERIPH_SLV_PWM]),
      .req_i (slv_req),
      .rsp_o (slv_rsp[`PERIPH_SLV_PWM]),
      .pwm_o (pwm_o)
   );

   periph_soc_control i_soc_control (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .sel_i          (slv_sel[`PERIPH_SLV_SOCCTRL]),
      .req_i          (slv_req),
      .rsp_o          (slv_rsp[`PERIPH_SLV_SOCCTRL]),
      .llc_event_i    (llc_event_i),
      .cluster_ctrl_o (cluster_ctrl_o)
   );

endmodule

// File: periph_subsystem.f
+incdir+hw
hw/periph_pkg.sv
hw/periph_bus_decoder.sv
hw/periph_gpio.sv
hw/periph_pwm_timer.sv
hw/periph_soc_control.sv
hw/periph_subsystem.sv
testbench/periph_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the peripheral subsystem testbench with Verilator and run it
verilator --binary --assert -Wno-fatal --top-module periph_subsystem_tb \
   -f periph_subsystem.f -o periph_subsystem_sim \
   && ./obj_dir/periph_subsystem_sim \
   || { echo "Simulation build or run failed"; exit 1; }

// File: testbench/periph_cases.txt
# W/R address data error: write data or expected read data, expected error flag
# G pins, E event count, P channel window high_count, C cluster_bits, O oe out (all hex)
O 0000 0000
C 4
R 00002000 00000004 0
R 00001014 00000000 0
R 00002004 00000000 0
W 00000000 ffff00ff 0
W 00000004 0000a5a5 0
O 00ff a5a5
R 00000000 000000ff 0
R 00000004 0000a5a5 0
G 1234
R 00000008 00001234 0
G beef
R 00000008 0000beef 0
W 00000008 00000001 1
R 0000000c 00000000 1
R 00003000 00000000 1
W 10000004 00000005 1
R 00001018 00000000 1
R 00002014 00000000 1
R 00000004 0000a5a5 0
W 00001000 00000007 0
W 00001004 00000003 0
W 00001008 00000000 0
W 0000100c 00000008 0
W 00001010 0000000c 0
P 2 8 0
W 00001014 00000001 0
P 0 8 3
P 1 8 0
P 2 8 8
P 3 8 8
P 0 10 6
R 0000100c 00000008 0
W 00001014 00000000 0
P 3 10 0
W 00002000 00000001 0
C 1
W 00002000 00000002 0
C 2
W 00002000 00000007 0
C 7
R 00002000 00000007 0
E 0 5
E 3 2
R 00002004 00000005 0
R 00002008 00000000 0
R 00002010 00000002 0
W 00002004 00000000 0
R 00002004 00000000 0
R 00002010 00000002 0

// File: testbench/periph_subsystem_tb.sv
/*
 * Testbench for the peripheral subsystem
 *  - clock, reset and cycle watchdog
 *  - case file reader and host port driver with random gaps and stalls
 *  - compare tasks for responses, cluster bits and counts
 */
`include "periph_defs.svh"

module periph_subsystem_tb
   import periph_pkg::*;
();

   logic                          clk_i;
   logic                          rst_i;
   logic                          req_valid_i;
   logic                          req_ready_o;
   periph_req_t                   req_i;
   logic                          rsp_valid_o;
   logic                          rsp_ready_i;
   periph_rsp_t                   rsp_o;
   logic [`PERIPH_NUM_GPIO-1:0]   gpio_i;
   logic [`PERIPH_NUM_GPIO-1:0]   gpio_o;
   logic [`PERIPH_NUM_GPIO-1:0]   gpio_oe_o;
   logic [`PERIPH_PWM_CH-1:0]     pwm_o;
   logic [`PERIPH_NUM_LLC_EV-1:0] llc_event_i;
   cluster_ctrl_t                 cluster_ctrl_o;

   int                            cycle_cnt;
   int                            cycle_limit;
   logic [7:0]                    case_op[$];
   logic [31:0]                   case_a[$];
   logic [31:0]                   case_b[$];
   logic [31:0]                   case_c[$];

   periph_subsystem periph_subsystem_inst (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .req_valid_i    (req_valid_i),
      .req_ready_o    (req_ready_o),
      .req_i          (req_i),
      .rsp_valid_o    (rsp_valid_o),
      .rsp_ready_i    (rsp_ready_i),
      .rsp_o          (rsp_o),
      .gpio_i         (gpio_i),
      .gpio_o         (gpio_o),
      .gpio_oe_o      (gpio_oe_o),
      .pwm_o          (pwm_o),
      .llc_event_i    (llc_event_i),
      .cluster_ctrl_o (cluster_ctrl_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   task automatic abort_run();
      $display("TEST RESULT: FAIL");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
         $display("Timeout: the cases did not finish within %0d cycles", cycle_limit);
         abort_run();
      end
   end

   task automatic check_rsp(input string name, input periph_rsp_t got, input periph_rsp_t exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got rdata %h err %b, expected rdata %h err %b",
                  $time, name, got.rdata, got.err, exp.rdata, exp.err);
         abort_run();
      end
   endtask

   task automatic check_cluster(input string name, input cluster_ctrl_t got,
                                input cluster_ctrl_t exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
         abort_run();
      end
   endtask

   // Inputs change one time unit after the rising edge
   task automatic next_cycle();
      @(posedge clk_i);
      #1;
   endtask

   task automatic load_cases();
      int               fd;
      int               n;
      int               window_total;
      logic [7:0]       op;
      logic [31:0]      a;
      logic [31:0]      b;
      logic [31:0]      c;
      logic [8*128-1:0] rest;
      window_total = 0;
      fd = $fopen("testbench/periph_cases.txt", "r");
      if (fd == 0) begin
         $display("Could not open the case file testbench/periph_cases.txt");
         abort_run();
      end
      while ($fscanf(fd, " %c", op) == 1) begin
         a = '0;
         b = '0;
         c = '0;
         if (op == "#") begin
            n = $fgets(rest, fd);
         end else begin
            case (op)
               "W", "R", "P": n = $fscanf(fd, "%h %h %h", a, b, c);
               "O", "E":      n = $fscanf(fd, "%h %h", a, b);
               "G", "C":      n = $fscanf(fd, "%h", a);
               default:       n = 0;
            endcase
            if (n < 1) begin
               $display("Unknown or malformed operation %c in the case file", op);
               abort_run();
            end
            if (op == "P") window_total += int'(b);
            case_op.push_back(op);
            case_a.push_back(a);
            case_b.push_back(b);
            case_c.push_back(c);
         end
      end
      $fclose(fd);
      cycle_limit = 40 * case_op.size() + window_total;
   endtask

   task automatic bus_access(input logic wr, input logic [31:0] addr,
                             input logic [31:0] wdata, output periph_rsp_t rsp);
      int gap;
      int stall;
      int lat;
      gap   = $urandom % 4;
      stall = $urandom % 5;
      repeat (gap) next_cycle();
      check_count("req_ready_o", int'(req_ready_o), 1);
      req_valid_i    = 1'b1;
      req_i.write    = wr;
      req_i.addr.raw = addr;
      req_i.wdata    = wdata;
      lat = 0;
      // Accepted on the first edge and valid after the second
      do begin
         next_cycle();
         req_valid_i = 1'b0;
         lat++;
      end while (!rsp_valid_o && lat < 4);
      check_count("response latency", lat, 2);
      repeat (stall) begin
         next_cycle();
         check_count("rsp_valid_o", int'(rsp_valid_o), 1);
         check_count("req_ready_o", int'(req_ready_o), 0);
      end
      rsp         = rsp_o;
      rsp_ready_i = 1'b1;
      next_cycle();
      rsp_ready_i = 1'b0;
      check_count("rsp_valid_o", int'(rsp_valid_o), 0);
   endtask

   task automatic pulse_event(input logic [1:0] idx, input int count);
      repeat (count) begin
         llc_event_i[idx] = 1'b1;
         next_cycle();
         llc_event_i[idx] = 1'b0;
         next_cycle();
      end
   endtask

   task automatic measure_pwm(input logic [1:0] ch, input int window, output int high);
      high = 0;
      repeat (window) begin
         if (pwm_o[ch]) high++;
         next_cycle();
      end
   endtask

   initial begin
      periph_rsp_t rsp;
      periph_rsp_t exp_rsp;
      int          high;
      rst_i       = 1'b1;
      req_valid_i = 1'b0;
      req_i       = '0;
      rsp_ready_i = 1'b0;
      gpio_i      = '0;
      llc_event_i = '0;
      cycle_cnt   = 0;
      void'($urandom(83204));
      load_cases();
      repeat (3) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
      check_count("req_ready_o", int'(req_ready_o), 1);
      check_count("rsp_valid_o", int'(rsp_valid_o), 0);
      check_count("pwm_o", int'(pwm_o), 0);
      for (int i = 0; i < case_op.size(); i++) begin
         case (case_op[i])
            "W", "R": begin
               bus_access(case_op[i] == "W", case_a[i], case_b[i], rsp);
               exp_rsp.rdata = (case_op[i] == "W") ? '0 : case_b[i];
               exp_rsp.err   = case_c[i][0];
               check_rsp("rsp_o", rsp, exp_rsp);
            end
            "G": begin
               gpio_i = case_a[i][`PERIPH_NUM_GPIO-1:0];
               // Two synchronizer stages and one spare cycle
               repeat (3) next_cycle();
            end
            "E": pulse_event(case_a[i][1:0], int'(case_b[i]));
            "P": begin
               measure_pwm(case_a[i][1:0], int'(case_b[i]), high);
               check_count($sformatf("pwm_o[%0d] high cycles", case_a[i]), high,
                           int'(case_c[i]));
            end
            "C": check_cluster("cluster_ctrl_o", cluster_ctrl_o,
                               cluster_ctrl_t'(case_a[i][2:0]));
            default: begin
               check_count("gpio_oe_o", int'(gpio_oe_o), int'(case_a[i]));
               check_count("gpio_o", int'(gpio_o), int'(case_b[i]));
            end
         endcase
      end
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule
